//--- sim.f
+incdir+.
vec_ctrl_pkg.sv
vec_req_if.sv
vec_decoder.sv
vec_csr_file.sv
vec_issue_stage.sv
vec_controller.sv
tb_vec_controller.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; the exit status is nonzero when the simulation fails
verilator --binary -j 0 -f sim.f --top-module tb_vec_controller -o tb_vec_controller \
  && ./obj_dir/tb_vec_controller \
  || exit 1

//--- tb_vec_controller.sv
// Table values assume VLEN 256; OPIVV entries wait until all earlier instructions have retired
`timescale 1ns/1ps
`default_nettype none

`include "vec_ctrl_settings.svh"

module tb_vec_controller;

  import vec_ctrl_pkg::*;

  localparam logic [1:0] KIND_NONE = 2'd0;
  localparam logic [1:0] KIND_RES  = 2'd1;
  localparam logic [1:0] KIND_DISP = 2'd2;

  typedef struct packed {
    logic [31:0]          instr;
    logic [`VEC_ELEN-1:0] rs1;
    logic                 acc;
    logic                 wb;
    logic [1:0]           kind;
    logic [`VEC_ELEN-1:0] data;
    vec_req_t             req;
    vlen_t                vl;
    vtype_t               vtype;
    logic                 drain;
  } entry_t;

  logic                    clk, reset;
  logic                    issue_valid, issue_ready;
  logic [`VEC_INSTR_W-1:0] issue_instr;
  logic [`VEC_ELEN-1:0]    issue_rs1;
  logic [`VEC_ID_W-1:0]    issue_id;
  logic                    resp_valid, resp_accept, resp_writeback;
  logic                    result_valid, result_ready;
  logic [`VEC_ID_W-1:0]    result_id;
  logic [4:0]              result_rd;
  logic [`VEC_ELEN-1:0]    result_data;
  logic                    vfu_valid, vfu_ready;
  vec_req_t                vfu_req;
  vlen_t                   vfu_vl;
  vtype_t                  vfu_vtype;

  entry_t      tbl [0:63];
  int          n_entries = 0;
  int          exp_q [$];
  logic [31:0] lfsr = 32'hc8ade388;
  // Reference copy of the configuration state, in program order
  vlen_t       m_vl = '0;
  vtype_t      m_vtype = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: SEW8, vlmul: LMUL1};

  vec_controller i_dut (
    .clk_i            (clk),
    .reset_i          (reset),
    .issue_valid_i    (issue_valid),
    .issue_ready_o    (issue_ready),
    .issue_instr_i    (issue_instr),
    .issue_rs1_i      (issue_rs1),
    .issue_id_i       (issue_id),
    .resp_valid_o     (resp_valid),
    .resp_accept_o    (resp_accept),
    .resp_writeback_o (resp_writeback),
    .result_valid_o   (result_valid),
    .result_ready_i   (result_ready),
    .result_id_o      (result_id),
    .result_rd_o      (result_rd),
    .result_data_o    (result_data),
    .vfu_valid_o      (vfu_valid),
    .vfu_ready_i      (vfu_ready),
    .vfu_req_o        (vfu_req),
    .vfu_vl_o         (vfu_vl),
    .vfu_vtype_o      (vfu_vtype)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_resp(input logic got_v, input logic got_a, input logic got_w,
                              input logic exp_v, input logic exp_a, input logic exp_w);
    if (got_v !== exp_v) begin
      fail_with($sformatf("FAIL resp_valid_o got %h expected %h", got_v, exp_v));
    end
    if (got_a !== exp_a) begin
      fail_with($sformatf("FAIL resp_accept_o got %h expected %h", got_a, exp_a));
    end
    if (got_w !== exp_w) begin
      fail_with($sformatf("FAIL resp_writeback_o got %h expected %h", got_w, exp_w));
    end
  endtask

  task automatic compare_result(input logic [`VEC_ID_W-1:0] got_id,
                                input logic [`VEC_ID_W-1:0] exp_id,
                                input logic [4:0]           got_rd,
                                input logic [4:0]           exp_rd,
                                input logic [`VEC_ELEN-1:0] got_data,
                                input logic [`VEC_ELEN-1:0] exp_data);
    if (got_id !== exp_id) begin
      fail_with($sformatf("FAIL result_id_o got %h expected %h", got_id, exp_id));
    end
    if (got_rd !== exp_rd) begin
      fail_with($sformatf("FAIL result_rd_o got %h expected %h", got_rd, exp_rd));
    end
    if (got_data !== exp_data) begin
      fail_with($sformatf("FAIL result_data_o got %h expected %h", got_data, exp_data));
    end
  endtask

  task automatic compare_dispatch(input vec_req_t got, input vec_req_t exp,
                                  input vlen_t got_vl, input vlen_t exp_vl,
                                  input vtype_t got_vt, input vtype_t exp_vt);
    if (got.id !== exp.id) begin
      fail_with($sformatf("FAIL vfu_req_o.id got %h expected %h", got.id, exp.id));
    end
    if ({got.vd, got.vs1, got.vs2} !== {exp.vd, exp.vs1, exp.vs2}) begin
      fail_with($sformatf("FAIL vfu_req_o vd/vs1/vs2 got %h expected %h",
                          {got.vd, got.vs1, got.vs2}, {exp.vd, exp.vs1, exp.vs2}));
    end
    if (got.funct6 !== exp.funct6) begin
      fail_with($sformatf("FAIL vfu_req_o.funct6 got %h expected %h", got.funct6,
                          exp.funct6));
    end
    if (got_vl !== exp_vl) begin
      fail_with($sformatf("FAIL vfu_vl_o got %h expected %h", got_vl, exp_vl));
    end
    if (got_vt !== exp_vt) begin
      fail_with($sformatf("FAIL vfu_vtype_o got %h expected %h", got_vt, exp_vt));
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    rand_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (rand_bit) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  ////////////////////////////////////////////////////////////

  task automatic push_entry(input logic [31:0] instr, input logic [31:0] rs1, input logic acc,
                            input logic wb, input logic [1:0] kind, input logic [31:0] data,
                            input logic drain);
    tbl[n_entries].instr      = instr;
    tbl[n_entries].rs1        = rs1;
    tbl[n_entries].acc        = acc;
    tbl[n_entries].wb         = wb;
    tbl[n_entries].kind       = kind;
    tbl[n_entries].data       = data;
    tbl[n_entries].req        = '0;
    tbl[n_entries].req.id     = `VEC_ID_W'(n_entries);
    tbl[n_entries].req.rd     = instr[11:7];
    tbl[n_entries].req.vd     = instr[11:7];
    tbl[n_entries].req.vs1    = instr[19:15];
    tbl[n_entries].req.vs2    = instr[24:20];
    tbl[n_entries].req.funct6 = instr[31:26];
    tbl[n_entries].vl         = m_vl;
    tbl[n_entries].vtype      = m_vtype;
    tbl[n_entries].drain      = drain;
    n_entries = n_entries + 1;
  endtask

  // vsetvli with rd x10, vma set and vta clear
  task automatic vsetvli_entry(input logic [4:0] rs1_idx, input logic [31:0] avl,
                               input vsew_e sew, input vlmul_e lmul);
    logic        legal;
    logic [31:0] num, den, vlmax, vl;
    legal = (sew <= SEW32) && (lmul != LMUL_RES) && (lmul != LMUL_F8) &&
            !((lmul == LMUL_F4) && (sew != SEW8)) && !((lmul == LMUL_F2) && (sew == SEW32));
    // VLMAX = VLEN * LMUL / SEW
    den = 32'd8 << sew;
    if (lmul < LMUL_RES) begin
      num = 32'(`VEC_VLEN) << lmul;
    end else begin
      num = 32'(`VEC_VLEN);
      den = den << (4'd8 - {1'b0, lmul});
    end
    vlmax = num / den;
    if (!legal) begin
      vl = 32'd0;
    end else if ((rs1_idx == 5'd0) || (avl >= vlmax)) begin
      vl = vlmax;
    end else begin
      vl = avl;
    end
    m_vl = vlen_t'(vl);
    if (legal) begin
      m_vtype = '{vill: 1'b0, vma: 1'b1, vta: 1'b0, vsew: sew, vlmul: lmul};
    end else begin
      m_vtype = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: SEW8, vlmul: LMUL1};
    end
    push_entry({4'b0000, 1'b1, 1'b0, sew, lmul, rs1_idx, 3'b111, 5'd10, 7'h57}, avl,
               1'b1, 1'b1, KIND_RES, vl, 1'b0);
  endtask

  task automatic csr_read_entry(input logic [4:0] rd, input csr_addr_e addr);
    logic [31:0] data;
    if (addr == VL) begin
      data = {23'd0, m_vl};
    end else if (addr == VTYPE) begin
      data = {m_vtype.vill, 23'd0, m_vtype.vma, m_vtype.vta, m_vtype.vsew, m_vtype.vlmul};
    end else if (addr == VLENB) begin
      data = 32'(`VEC_VLEN / 8);
    end else begin
      data = 32'd0;
    end
    push_entry({addr, 5'd0, 3'b010, rd, 7'h73}, 32'd0, 1'b1, rd != 5'd0, KIND_RES, data, 1'b0);
  endtask

  task automatic opivv_entry(input logic [5:0] f6, input logic [4:0] vd, input logic [4:0] vs1,
                             input logic [4:0] vs2);
    logic acc;
    acc = !m_vtype.vill;
    push_entry({f6, 1'b1, vs2, vs1, 3'b000, vd, 7'h57}, 32'd0, acc, 1'b0,
               acc ? KIND_DISP : KIND_NONE, 32'd0, 1'b1);
  endtask

  task automatic undefined_entry(input logic [31:0] instr);
    push_entry(instr, 32'd0, 1'b0, 1'b0, KIND_NONE, 32'd0, 1'b0);
  endtask

  task automatic build_table();
    // State right after reset
    csr_read_entry(5'd5, VTYPE);
    csr_read_entry(5'd6, VL);
    opivv_entry(6'h00, 5'd1, 5'd2, 5'd3);
    // Legal configurations below, at and above VLMAX
    vsetvli_entry(5'd11, 32'd10, SEW8, LMUL1);
    csr_read_entry(5'd6, VL);
    opivv_entry(6'h00, 5'd4, 5'd5, 5'd6);
    vsetvli_entry(5'd11, 32'd32, SEW16, LMUL2);
    vsetvli_entry(5'd12, 32'd100, SEW32, LMUL8);
    csr_read_entry(5'd6, VL);
    vsetvli_entry(5'd0, 32'd3, SEW8, LMUL8);
    csr_read_entry(5'd7, VTYPE);
    opivv_entry(6'h09, 5'd8, 5'd16, 5'd24);
    vsetvli_entry(5'd13, 32'd5, SEW16, LMUL_F2);
    vsetvli_entry(5'd0, 32'd0, SEW8, LMUL_F4);
    csr_read_entry(5'd6, VL);
    opivv_entry(6'h02, 5'd31, 5'd30, 5'd29);
    // Illegal vtypes
    vsetvli_entry(5'd11, 32'd7, SEW64, LMUL1);
    csr_read_entry(5'd5, VTYPE);
    opivv_entry(6'h00, 5'd1, 5'd1, 5'd1);
    vsetvli_entry(5'd11, 32'd7, SEW8, LMUL_RES);
    vsetvli_entry(5'd11, 32'd7, SEW8, LMUL_F8);
    vsetvli_entry(5'd11, 32'd7, SEW16, LMUL_F4);
    csr_read_entry(5'd5, VTYPE);
    csr_read_entry(5'd6, VL);
    // Undefined encodings: addi, csrrs with rs1 x1, fflags, vsetvl, OPMVV
    undefined_entry(32'h0000_0013);
    undefined_entry({12'hC20, 5'd1, 3'b010, 5'd3, 7'h73});
    undefined_entry({12'h001, 5'd0, 3'b010, 5'd3, 7'h73});
    undefined_entry(32'h8000_7057);
    undefined_entry({6'h00, 1'b1, 5'd2, 5'd1, 3'b010, 5'd3, 7'h57});
    csr_read_entry(5'd7, VLENB);
    csr_read_entry(5'd0, VLENB);
    csr_read_entry(5'd8, VSTART);
    csr_read_entry(5'd0, VSTART);
    vsetvli_entry(5'd14, 32'd20, SEW32, LMUL4);
    opivv_entry(6'h2c, 5'd9, 5'd10, 5'd11);
    csr_read_entry(5'd6, VL);
    opivv_entry(6'h01, 5'd12, 5'd13, 5'd14);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int   idx;
    int   resp_idx;
    int   stall;
    logic resp_due;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_id     = '0;
    result_ready = 1'b0;
    vfu_ready    = 1'b0;
    build_table();
    repeat (8) begin
      @(negedge clk);
      if ((issue_ready !== 1'b0) || (resp_valid !== 1'b0) || (result_valid !== 1'b0) ||
          (vfu_valid !== 1'b0)) begin
        fail_with("DUT handshake outputs are not low during reset");
      end
    end
    reset = 1'b0;
    stall = 0;
    // issue_ready_o must rise exactly one cycle after reset release
    while (issue_ready !== 1'b1) begin
      if (stall > 0) begin
        fail_with("issue_ready_o did not rise one cycle after reset release");
      end
      stall = stall + 1;
      @(negedge clk);
    end

    idx      = 0;
    resp_idx = 0;
    resp_due = 1'b0;
    stall    = 0;
    while ((idx < n_entries) || (exp_q.size() != 0)) begin
      // Response belongs to the issue handshake one edge earlier
      if (resp_due) begin
        compare_resp(resp_valid, resp_accept, resp_writeback, 1'b1, tbl[resp_idx].acc,
                     tbl[resp_idx].wb);
      end else begin
        compare_resp(resp_valid, resp_accept, resp_writeback, 1'b0, 1'b0, 1'b0);
      end
      result_ready = rand_bit();
      vfu_ready    = rand_bit();
      issue_valid  = (idx < n_entries) && !(tbl[idx].drain && (exp_q.size() != 0));
      if (issue_valid) begin
        issue_instr = tbl[idx].instr;
        issue_rs1   = tbl[idx].rs1;
        issue_id    = tbl[idx].req.id;
      end
      #1;
      stall = stall + 1;
      if (result_valid && result_ready) begin
        if ((exp_q.size() == 0) || (tbl[exp_q[0]].kind != KIND_RES)) begin
          fail_with("Result returned where none was expected");
        end
        compare_result(result_id, tbl[exp_q[0]].req.id, result_rd, tbl[exp_q[0]].req.rd,
                       result_data, tbl[exp_q[0]].data);
        void'(exp_q.pop_front());
        stall = 0;
      end
      if (vfu_valid && vfu_ready) begin
        if ((exp_q.size() == 0) || (tbl[exp_q[0]].kind != KIND_DISP)) begin
          fail_with("Dispatch to the VFU where none was expected");
        end
        compare_dispatch(vfu_req, tbl[exp_q[0]].req, vfu_vl, tbl[exp_q[0]].vl, vfu_vtype,
                         tbl[exp_q[0]].vtype);
        void'(exp_q.pop_front());
        stall = 0;
      end
      resp_due = issue_valid && issue_ready;
      if (resp_due) begin
        resp_idx = idx;
        if (tbl[idx].kind != KIND_NONE) begin
          exp_q.push_back(idx);
        end
        idx   = idx + 1;
        stall = 0;
      end
      if (stall > 200) begin
        fail_with("Timeout: no handshake on any port for 200 cycles");
      end
      @(negedge clk);
    end

    issue_valid = 1'b0;
    if (resp_due) begin
      compare_resp(resp_valid, resp_accept, resp_writeback, 1'b1, tbl[resp_idx].acc,
                   tbl[resp_idx].wb);
    end
    if (result_valid || vfu_valid) begin
      fail_with("DUT still presents output after the last instruction retired");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vec_controller.sv
// Two instructions in flight at most; no scoreboard, so the VFU must order its own hazards
`timescale 1ns/1ps
`default_nettype none

`include "vec_ctrl_settings.svh"

module vec_controller (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Issue from the scalar core
  input  logic                      issue_valid_i,
  output logic                      issue_ready_o,
  input  logic [`VEC_INSTR_W-1:0]   issue_instr_i,
  input  logic [`VEC_ELEN-1:0]      issue_rs1_i,
  input  logic [`VEC_ID_W-1:0]      issue_id_i,
  output logic                      resp_valid_o,
  output logic                      resp_accept_o,
  output logic                      resp_writeback_o,
  // Scalar result
  output logic                      result_valid_o,
  input  logic                      result_ready_i,
  output logic [`VEC_ID_W-1:0]      result_id_o,
  output logic [4:0]                result_rd_o,
  output logic [`VEC_ELEN-1:0]      result_data_o,
  // VFU dispatch
  output logic                      vfu_valid_o,
  input  logic                      vfu_ready_i,
  output vec_ctrl_pkg::vec_req_t    vfu_req_o,
  output vec_ctrl_pkg::vlen_t       vfu_vl_o,
  output vec_ctrl_pkg::vtype_t      vfu_vtype_o
);

  import vec_ctrl_pkg::*;

  vlen_t                vl, cfg_vl;
  vtype_t               vtype, cfg_vtype;
  logic [`VEC_ELEN-1:0] csr_rdata, cfg_avl;
  logic                 cfg_en, cfg_avl_max;
  csr_addr_e            csr_addr;

  vec_req_if i_req_if ();

  vec_decoder i_decoder (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_instr_i    (issue_instr_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_id_i       (issue_id_i),
    .vill_i           (vtype.vill),
    .resp_valid_o     (resp_valid_o),
    .resp_accept_o    (resp_accept_o),
    .resp_writeback_o (resp_writeback_o),
    .req              (i_req_if.producer)
  );

  vec_csr_file i_csr_file (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_en_i      (cfg_en),
    .cfg_vtype_i   (cfg_vtype),
    .cfg_avl_i     (cfg_avl),
    .cfg_avl_max_i (cfg_avl_max),
    .csr_addr_i    (csr_addr),
    .vl_o          (vl),
    .vtype_o       (vtype),
    .cfg_vl_o      (cfg_vl),
    .csr_rdata_o   (csr_rdata)
  );

  vec_issue_stage i_issue_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req            (i_req_if.consumer),
    .vl_i           (vl),
    .vtype_i        (vtype),
    .cfg_vl_i       (cfg_vl),
    .csr_rdata_i    (csr_rdata),
    .cfg_en_o       (cfg_en),
    .cfg_vtype_o    (cfg_vtype),
    .cfg_avl_o      (cfg_avl),
    .cfg_avl_max_o  (cfg_avl_max),
    .csr_addr_o     (csr_addr),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .vfu_valid_o    (vfu_valid_o),
    .vfu_ready_i    (vfu_ready_i),
    .vfu_req_o      (vfu_req_o),
    .vfu_vl_o       (vfu_vl_o),
    .vfu_vtype_o    (vfu_vtype_o)
  );

endmodule

`default_nettype wire

//--- vec_issue_stage.sv
// One entry deep and in order; a stalled entry blocks everything behind it
`timescale 1ns/1ps
`default_nettype none

`include "vec_ctrl_settings.svh"

module vec_issue_stage (
  input  logic                      clk_i,
  input  logic                      reset_i,
  vec_req_if.consumer               req,
  input  vec_ctrl_pkg::vlen_t       vl_i,
  input  vec_ctrl_pkg::vtype_t      vtype_i,
  input  vec_ctrl_pkg::vlen_t       cfg_vl_i,
  input  logic [`VEC_ELEN-1:0]      csr_rdata_i,
  output logic                      cfg_en_o,
  output vec_ctrl_pkg::vtype_t      cfg_vtype_o,
  output logic [`VEC_ELEN-1:0]      cfg_avl_o,
  output logic                      cfg_avl_max_o,
  output vec_ctrl_pkg::csr_addr_e   csr_addr_o,
  output logic                      result_valid_o,
  input  logic                      result_ready_i,
  output logic [`VEC_ID_W-1:0]      result_id_o,
  output logic [4:0]                result_rd_o,
  output logic [`VEC_ELEN-1:0]      result_data_o,
  output logic                      vfu_valid_o,
  input  logic                      vfu_ready_i,
  output vec_ctrl_pkg::vec_req_t    vfu_req_o,
  output vec_ctrl_pkg::vlen_t       vfu_vl_o,
  output vec_ctrl_pkg::vtype_t      vfu_vtype_o
);

  import vec_ctrl_pkg::*;

  logic     buf_valid_q;
  vec_req_t buf_q;
  logic     to_vfu;
  logic     leave;

  ////////////////////////////////////////////////////////////
  // Request buffer
  ////////////////////////////////////////////////////////////

  assign to_vfu = (buf_q.ex_unit == VFU);

  // Entry leaves on the handshake of whichever port it sits on
  assign leave = (vfu_valid_o && vfu_ready_i) || (result_valid_o && result_ready_i);

  assign req.ready = !buf_valid_q || leave;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else if (req.ready) begin
      buf_valid_q <= req.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid && req.ready) begin
      buf_q <= req.req;
    end
  end

  ////////////////////////////////////////////////////////////
  // Dispatch to the VFU
  ////////////////////////////////////////////////////////////

  // vl and vtype cannot change while this entry is at the head
  assign vfu_valid_o = buf_valid_q && to_vfu;
  assign vfu_req_o   = buf_q;
  assign vfu_vl_o    = vl_i;
  assign vfu_vtype_o = vtype_i;

  ////////////////////////////////////////////////////////////
  // Controller instructions and write-back
  ////////////////////////////////////////////////////////////

  assign cfg_vtype_o   = buf_q.vtype;
  assign cfg_avl_o     = buf_q.avl;
  assign cfg_avl_max_o = buf_q.avl_max;
  assign csr_addr_o    = buf_q.csr_addr;

  assign result_valid_o = buf_valid_q && !to_vfu;
  assign result_id_o    = buf_q.id;
  assign result_rd_o    = buf_q.rd;

  // vsetvli returns the vl it is about to write
  assign result_data_o = (buf_q.op == VCFG) ? `VEC_ELEN'(cfg_vl_i) : csr_rdata_i;

  // Commit vl/vtype on the same edge as the result handshake
  assign cfg_en_o = result_valid_o && result_ready_i && (buf_q.op == VCFG);

endmodule

`default_nettype wire

//--- vec_csr_file.sv
// vstart is read-only zero; keep-vl vsetvli and CSR writes are not supported
`timescale 1ns/1ps
`default_nettype none

`include "vec_ctrl_settings.svh"

module vec_csr_file (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cfg_en_i,
  input  vec_ctrl_pkg::vtype_t      cfg_vtype_i,
  input  logic [`VEC_ELEN-1:0]      cfg_avl_i,
  input  logic                      cfg_avl_max_i,
  input  vec_ctrl_pkg::csr_addr_e   csr_addr_i,
  output vec_ctrl_pkg::vlen_t       vl_o,
  output vec_ctrl_pkg::vtype_t      vtype_o,
  output vec_ctrl_pkg::vlen_t       cfg_vl_o,
  output logic [`VEC_ELEN-1:0]      csr_rdata_o
);

  import vec_ctrl_pkg::*;

  vlen_t  vl_q;
  vtype_t vtype_q;
  vlen_t  vlmax;
  vlen_t  cfg_vl;
  logic   cfg_illegal;

  ////////////////////////////////////////////////////////////
  // vsetvli evaluation
  ////////////////////////////////////////////////////////////

  // Fractional LMUL must still hold one SEW element in ELEN
  assign cfg_illegal = (cfg_vtype_i.vsew > SEW32) ||
                       (cfg_vtype_i.vlmul == LMUL_RES) ||
                       (cfg_vtype_i.vlmul == LMUL_F8) ||
                       ((cfg_vtype_i.vlmul == LMUL_F4) && (cfg_vtype_i.vsew != SEW8)) ||
                       ((cfg_vtype_i.vlmul == LMUL_F2) && (cfg_vtype_i.vsew == SEW32));

  always_comb begin
    vlmax = vlen_t'(`VEC_VLEN / 8) >> cfg_vtype_i.vsew;
    case (cfg_vtype_i.vlmul)
      LMUL2:   vlmax = vlmax << 1;
      LMUL4:   vlmax = vlmax << 2;
      LMUL8:   vlmax = vlmax << 3;
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      default: vlmax = vlmax;
    endcase
  end

  always_comb begin
    if (cfg_illegal) begin
      cfg_vl = '0;
    end else if (cfg_avl_max_i || (cfg_avl_i >= `VEC_ELEN'(vlmax))) begin
      cfg_vl = vlmax;
    end else begin
      cfg_vl = vlen_t'(cfg_avl_i);
    end
  end

  assign cfg_vl_o = cfg_vl;

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vl_q    <= '0;
      vtype_q <= VTYPE_ILL;
    end else if (cfg_en_i) begin
      vl_q    <= cfg_vl;
      vtype_q <= cfg_illegal ? VTYPE_ILL : cfg_vtype_i;
    end
  end

  assign vl_o    = vl_q;
  assign vtype_o = vtype_q;

  // vtype read follows the RVV layout with vill in the top bit
  always_comb begin
    case (csr_addr_i)
      VL:      csr_rdata_o = `VEC_ELEN'(vl_q);
      VTYPE:   csr_rdata_o = {vtype_q.vill, {(`VEC_ELEN - 9){1'b0}}, vtype_q.vma,
                              vtype_q.vta, vtype_q.vsew, vtype_q.vlmul};
      VLENB:   csr_rdata_o = `VEC_ELEN'(`VEC_VLEN / 8);
      default: csr_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- vec_decoder.sv
// OPIVV is checked against the committed vtype only, so a vsetvli still in flight is not seen
`timescale 1ns/1ps
`default_nettype none

`include "vec_ctrl_settings.svh"

module vec_decoder (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    issue_valid_i,
  output logic                    issue_ready_o,
  input  logic [`VEC_INSTR_W-1:0] issue_instr_i,
  input  logic [`VEC_ELEN-1:0]    issue_rs1_i,
  input  logic [`VEC_ID_W-1:0]    issue_id_i,
  input  logic                    vill_i,
  output logic                    resp_valid_o,
  output logic                    resp_accept_o,
  output logic                    resp_writeback_o,
  vec_req_if.producer             req
);

  import vec_ctrl_pkg::*;

  logic       en_q;
  logic       fire;
  logic       is_vcfg, is_vcsr, is_varith, csr_ok;
  logic       accept, writeback;
  logic [4:0] rd_f, rs1_f;
  vec_req_t   dec_req;

  assign rd_f  = issue_instr_i[11:7];
  assign rs1_f = issue_instr_i[19:15];

  ////////////////////////////////////////////////////////////
  // Instruction recognition
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (issue_instr_i[31:20])
      VSTART, VL, VTYPE, VLENB: csr_ok = 1'b1;
      default:                  csr_ok = 1'b0;
    endcase
  end

  // vsetvli has bit 31 clear, OPIVV uses funct3 0
  assign is_vcfg   = (issue_instr_i[6:0] == 7'h57) && (issue_instr_i[14:12] == 3'b111) &&
                     !issue_instr_i[31];
  assign is_varith = (issue_instr_i[6:0] == 7'h57) && (issue_instr_i[14:12] == 3'b000);
  // csrrs rd, csr, x0
  assign is_vcsr   = (issue_instr_i[6:0] == 7'h73) && (issue_instr_i[14:12] == 3'b010) &&
                     (rs1_f == 5'd0) && csr_ok;

  assign accept    = is_vcfg || is_vcsr || (is_varith && !vill_i);
  assign writeback = is_vcfg || (is_vcsr && (rd_f != 5'd0));

  always_comb begin
    dec_req          = '0;
    dec_req.op       = is_vcfg ? VCFG : (is_vcsr ? VCSR_READ : VARITH);
    dec_req.ex_unit  = is_varith ? VFU : CON;
    dec_req.id       = issue_id_i;
    dec_req.rd       = rd_f;
    dec_req.vd       = rd_f;
    dec_req.vs1      = rs1_f;
    dec_req.vs2      = issue_instr_i[24:20];
    dec_req.use_rd   = writeback;
    dec_req.csr_addr = csr_addr_e'(issue_instr_i[31:20]);
    dec_req.vtype    = '{vill: 1'b0, vma: issue_instr_i[27], vta: issue_instr_i[26],
                         vsew: vsew_e'(issue_instr_i[25:23]),
                         vlmul: vlmul_e'(issue_instr_i[22:20])};
    dec_req.avl      = issue_rs1_i;
    dec_req.avl_max  = (rs1_f == 5'd0);
    dec_req.funct6   = issue_instr_i[31:26];
  end

  ////////////////////////////////////////////////////////////
  // Response and request register
  ////////////////////////////////////////////////////////////

  // Free, or emptied by the issue stage on this edge
  assign issue_ready_o = en_q && (!req.valid || req.ready);
  assign fire          = issue_valid_i && issue_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q             <= 1'b0;
      resp_valid_o     <= 1'b0;
      resp_accept_o    <= 1'b0;
      resp_writeback_o <= 1'b0;
      req.valid        <= 1'b0;
    end else begin
      en_q             <= 1'b1;
      resp_valid_o     <= fire;
      resp_accept_o    <= fire && accept;
      resp_writeback_o <= fire && writeback;
      if (fire && accept) begin
        req.valid <= 1'b1;
      end else if (req.ready) begin
        req.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && accept) begin
      req.req <= dec_req;
    end
  end

endmodule

`default_nettype wire

//--- vec_req_if.sv
// Carries accepted instructions only; a transfer needs valid and ready high on one edge
`timescale 1ns/1ps
`default_nettype none

interface vec_req_if;

  import vec_ctrl_pkg::*;

  logic     valid;
  logic     ready;
  vec_req_t req;

  // Decoder side, holds req stable while valid is high
  modport producer (
    output valid,
    output req,
    input  ready
  );

  // Issue stage side, ready does not look at valid
  modport consumer (
    input  valid,
    input  req,
    output ready
  );

endinterface

`default_nettype wire

//--- vec_ctrl_pkg.sv
// Holds only the RVV subset used here: vsetvli, CSR reads and OPIVV arithmetic
`default_nettype none

`include "vec_ctrl_settings.svh"

package vec_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // vtype fields
  ////////////////////////////////////////////////////////////

  // SEW64 exists in the encoding but is illegal with ELEN 32
  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2,
    SEW64 = 3'd3
  } vsew_e;

  typedef enum logic [2:0] {
    LMUL1    = 3'd0,
    LMUL2    = 3'd1,
    LMUL4    = 3'd2,
    LMUL8    = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    logic   vma;
    logic   vta;
    vsew_e  vsew;
    vlmul_e vlmul;
  } vtype_t;

  // State after reset and after an illegal vsetvli
  localparam vtype_t VTYPE_ILL = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: SEW8, vlmul: LMUL1};

  // Holds VLMAX for SEW8 and LMUL8
  typedef logic [$clog2(`VEC_VLEN):0] vlen_t;

  ////////////////////////////////////////////////////////////
  // Decoded request
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    CON = 1'b0,
    VFU = 1'b1
  } ex_unit_e;

  typedef enum logic [1:0] {
    VCFG      = 2'd0,
    VCSR_READ = 2'd1,
    VARITH    = 2'd2
  } vec_op_e;

  typedef enum logic [11:0] {
    VSTART = 12'h008,
    VL     = 12'hC20,
    VTYPE  = 12'hC21,
    VLENB  = 12'hC22
  } csr_addr_e;

  typedef struct packed {
    vec_op_e              op;
    ex_unit_e             ex_unit;
    logic [`VEC_ID_W-1:0] id;
    logic [4:0]           rd;
    logic [4:0]           vd;
    logic [4:0]           vs1;
    logic [4:0]           vs2;
    logic                 use_rd;
    csr_addr_e            csr_addr;
    vtype_t               vtype;   // Requested by vsetvli, vill always clear
    logic [`VEC_ELEN-1:0] avl;
    logic                 avl_max; // rs1 was x0
    logic [5:0]           funct6;
  } vec_req_t;

endpackage

`default_nettype wire

//--- vec_ctrl_settings.svh
// Assumes ELEN is 32 and VLEN is a power of two from 64 up to 1024 bits
`ifndef VEC_CTRL_SETTINGS_SVH
`define VEC_CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Vector unit geometry
////////////////////////////////////////////////////////////

// Vector register length in bits
`define VEC_VLEN 256

// Scalar data width, also the width of rs1 and of results
`define VEC_ELEN 32

////////////////////////////////////////////////////////////
// Scalar core interface
////////////////////////////////////////////////////////////

`define VEC_INSTR_W 32

// Instruction id as handed out by the scalar core
`define VEC_ID_W 4

`endif
